// ==== vlog.f ====
source/bp_pkg.sv
source/bp_update_if.sv
source/btb.sv
source/gshare.sv
source/branch_resolver.sv
source/branch_predictor.sv
tests/branch_predictor_properties.sv
tests/branch_predictor_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = branch_predictor_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/branch_predictor_tb.sv ====
module branch_predictor_tb;
    import bp_pkg::*;

    localparam int btb_entries     = default_btb_entries;
    localparam int ghr_bits        = default_ghr_bits;
    localparam int pht_entries     = 2 ** ghr_bits;
    localparam int idx_bits        = $clog2(btb_entries);
    localparam int half_period     = 50;
    localparam int settle_time     = 10;
    localparam int watchdog_cycles = 5000;
    // an ordinary ALU opcode that is never a control transfer
    localparam logic [6:0] op_addi = 7'b0010011;

    // one fetched control instruction waiting for its resolve
    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [6:0]          op;
        logic [xlen-1:0]     target;
        logic                taken;
        logic                pred_taken;
        logic [xlen-1:0]     pred_next;
        logic [ghr_bits-1:0] index;
    } pending_t;

    logic                clk;
    logic                reset_i;
    logic                ghr_clear_i;
    logic [xlen-1:0]     pc_i;
    logic [6:0]          op_i;
    logic [xlen-1:0]     pred_next_pc_o;
    logic                pred_taken_o;
    logic [ghr_bits-1:0] pht_index_o;
    logic                ex_valid_i;
    logic [6:0]          ex_op_i;
    logic [xlen-1:0]     ex_pc_i;
    logic [xlen-1:0]     ex_target_i;
    logic                ex_taken_i;
    logic                ex_pred_taken_i;
    logic [xlen-1:0]     ex_pred_next_pc_i;
    logic [ghr_bits-1:0] ex_pht_index_i;
    logic                mispredict_o;
    logic [xlen-1:0]     redirect_pc_o;

    // reference copy of the BTB, the history and the counters
    logic [xlen-1:0]     model_target [btb_entries];
    logic [xlen-1:0]     model_tag    [btb_entries];
    logic                model_valid  [btb_entries];
    logic [ghr_bits-1:0] model_ghr;
    ctr_t                model_pht    [pht_entries];

    pending_t pending_q[$];
    int       checks_done;
    int       seed;

    branch_predictor #(
        .num_btb_entries(btb_entries),
        .num_ghr_bits   (ghr_bits)
    ) i_dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .ghr_clear_i      (ghr_clear_i),
        .pc_i             (pc_i),
        .op_i             (op_i),
        .pred_next_pc_o   (pred_next_pc_o),
        .pred_taken_o     (pred_taken_o),
        .pht_index_o      (pht_index_o),
        .ex_valid_i       (ex_valid_i),
        .ex_op_i          (ex_op_i),
        .ex_pc_i          (ex_pc_i),
        .ex_target_i      (ex_target_i),
        .ex_taken_i       (ex_taken_i),
        .ex_pred_taken_i  (ex_pred_taken_i),
        .ex_pred_next_pc_i(ex_pred_next_pc_i),
        .ex_pht_index_i   (ex_pht_index_i),
        .mispredict_o     (mispredict_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    bind branch_predictor branch_predictor_properties i_props (
        .clk          (clk),
        .reset_i      (reset_i),
        .ex_valid_i   (ex_valid_i),
        .mispredict_i (mispredict_o),
        .pred_taken_i (pred_taken_o),
        .redirect_pc_i(redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // overall limit so that a stuck test still ends the run
    initial begin
        for (int i = 0; i < watchdog_cycles; i++) begin
            @(posedge clk);
        end
        abort_run("timeout, the tests did not finish within the cycle limit");
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
        checks_done++;
    endtask

    // the BTB row counts words, the tag is everything above the row bits
    function automatic int btb_row(input logic [xlen-1:0] pc);
        return int'((pc >> 2) % btb_entries);
    endfunction

    function automatic logic [xlen-1:0] btb_tag(input logic [xlen-1:0] pc);
        return pc >> (idx_bits + 2);
    endfunction

    function automatic logic [ghr_bits-1:0] model_index(input logic [xlen-1:0] pc);
        return model_ghr ^ ghr_bits'(pc >> 2);
    endfunction

    function automatic logic model_taken(input logic [xlen-1:0] pc, input logic [6:0] op);
        logic hit;
        hit = model_valid[btb_row(pc)] && (model_tag[btb_row(pc)] == btb_tag(pc));
        if (!hit) return 1'b0;
        if (op == op_jal || op == op_jalr) return 1'b1;
        if (op == op_branch) return model_pht[model_index(pc)][1];
        return 1'b0;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < btb_entries; i++) begin
            model_valid[i] = 1'b0;
        end
        for (int i = 0; i < pht_entries; i++) begin
            model_pht[i] = ctr_reset;
        end
        model_ghr = '0;
    endtask

    // applies what the DUT commits at a rising edge
    task automatic model_commit();
        int   row;
        ctr_t ctr;
        logic is_ctrl;
        logic is_branch;
        row       = btb_row(ex_pc_i);
        is_branch = ex_valid_i && (ex_op_i == op_branch);
        is_ctrl   = (ex_op_i == op_branch) || (ex_op_i == op_jal) || (ex_op_i == op_jalr);
        if (reset_i) begin
            model_reset();
        end else begin
            if (ex_valid_i && is_ctrl && ex_taken_i) begin
                model_valid[row]  = 1'b1;
                model_tag[row]    = btb_tag(ex_pc_i);
                model_target[row] = ex_target_i;
            end
            if (is_branch) begin
                ctr = model_pht[ex_pht_index_i];
                if (ex_taken_i && ctr != ctr_strong_t) begin
                    ctr = ctr + 2'd1;
                end else if (!ex_taken_i && ctr != ctr_strong_nt) begin
                    ctr = ctr - 2'd1;
                end
                model_pht[ex_pht_index_i] = ctr;
            end
            // the clear wins over the shift
            if (ghr_clear_i) begin
                model_ghr = '0;
            end else if (is_branch) begin
                model_ghr = {model_ghr[ghr_bits-2:0], ex_taken_i};
            end
        end
    endtask

    // compares every output with what the model expects in this cycle
    task automatic check_model();
        logic            exp_taken;
        logic [xlen-1:0] exp_next;
        logic [xlen-1:0] actual_next;
        logic            is_ctrl;
        logic            exp_mis;
        exp_taken   = model_taken(pc_i, op_i);
        exp_next    = exp_taken ? model_target[btb_row(pc_i)] : pc_i + 32'd4;
        is_ctrl     = (ex_op_i == op_branch) || (ex_op_i == op_jal) || (ex_op_i == op_jalr);
        actual_next = ex_taken_i ? ex_target_i : ex_pc_i + 32'd4;
        exp_mis     = ex_valid_i && is_ctrl && (ex_pred_next_pc_i != actual_next);
        check_eq("pht_index_o", 32'(pht_index_o), 32'(model_index(pc_i)));
        check_eq("pred_taken_o", 32'(pred_taken_o), 32'(exp_taken));
        check_eq("pred_next_pc_o", pred_next_pc_o, exp_next);
        check_eq("mispredict_o", 32'(mispredict_o), 32'(exp_mis));
        if (exp_mis) begin
            check_eq("redirect_pc_o", redirect_pc_o, actual_next);
        end
    endtask

    task automatic drive_idle();
        ghr_clear_i       = 1'b0;
        pc_i              = '0;
        op_i              = op_addi;
        ex_valid_i        = 1'b0;
        ex_op_i           = op_addi;
        ex_pc_i           = '0;
        ex_target_i       = '0;
        ex_taken_i        = 1'b0;
        ex_pred_taken_i   = 1'b0;
        ex_pred_next_pc_i = '0;
        ex_pht_index_i    = '0;
    endtask

    task automatic set_lookup(input logic [xlen-1:0] pc, input logic [6:0] op);
        pc_i = pc;
        op_i = op;
    endtask

    task automatic set_resolve(input pending_t p);
        ex_valid_i        = 1'b1;
        ex_op_i           = p.op;
        ex_pc_i           = p.pc;
        ex_target_i       = p.target;
        ex_taken_i        = p.taken;
        ex_pred_taken_i   = p.pred_taken;
        ex_pred_next_pc_i = p.pred_next;
        ex_pht_index_i    = p.index;
    endtask

    // keeps the current fetch prediction together with the real outcome
    task automatic capture(input logic [xlen-1:0] target, input logic taken,
                           output pending_t p);
        p.pc         = pc_i;
        p.op         = op_i;
        p.target     = target;
        p.taken      = taken;
        p.pred_taken = pred_taken_o;
        p.pred_next  = pred_next_pc_o;
        p.index      = pht_index_o;
    endtask

    task automatic settle();
        #settle_time;
        check_model();
    endtask

    // inputs change only on the falling edge after the model has caught up
    task automatic advance();
        @(posedge clk);
        model_commit();
        @(negedge clk);
        drive_idle();
    endtask

    task automatic test_after_reset();
        logic [xlen-1:0] pc;
        for (int i = 0; i < 4; i++) begin
            pc = 32'h0000_0100 + 32'(i) * 32'h0000_0244;
            set_lookup(pc, (i % 2 == 0) ? op_jal : op_branch);
            settle();
            check_eq("pred_taken_o after reset", 32'(pred_taken_o), 32'd0);
            check_eq("pred_next_pc_o after reset", pred_next_pc_o, pc + 32'd4);
            advance();
        end
    endtask

    task automatic test_jump_training();
        pending_t p;
        set_lookup(32'h0000_0400, op_jal);
        settle();
        capture(32'h0000_0880, 1'b1, p);
        advance();
        set_resolve(p);
        settle();
        check_eq("mispredict_o of untrained jal", 32'(mispredict_o), 32'd1);
        check_eq("redirect_pc_o of untrained jal", redirect_pc_o, 32'h0000_0880);
        advance();
        set_lookup(32'h0000_0400, op_jal);
        settle();
        check_eq("pred_taken_o of trained jal", 32'(pred_taken_o), 32'd1);
        check_eq("pred_next_pc_o of trained jal", pred_next_pc_o, 32'h0000_0880);
        advance();
    endtask

    task automatic test_counter_history();
        pending_t            p;
        logic                found;
        logic [ghr_bits-1:0] idx;
        found = 1'b0;
        idx   = '0;
        // each taken resolve shifts the history, so the index walks until it settles
        for (int iter = 0; iter < 16 && !found; iter++) begin
            set_lookup(32'h0000_2040, op_branch);
            settle();
            if (pred_taken_o) begin
                found = 1'b1;
                idx   = pht_index_o;
            end else begin
                capture(32'h0000_2100, 1'b1, p);
                advance();
                set_resolve(p);
                settle();
            end
            advance();
        end
        if (!found) begin
            abort_run("the branch was never predicted taken within the iteration limit");
        end
        check_eq("counter when first predicted taken",
                 32'(i_dut.i_gshare.pht_mem[idx]), 32'(ctr_weak_t));
        // a wrapping counter would drop back to not taken in here
        repeat (4) begin
            set_lookup(32'h0000_2040, op_branch);
            settle();
            check_eq("pred_taken_o while saturating", 32'(pred_taken_o), 32'd1);
            capture(32'h0000_2100, 1'b1, p);
            advance();
            set_resolve(p);
            settle();
            advance();
        end
        check_eq("counter after saturation",
                 32'(i_dut.i_gshare.pht_mem[idx]), 32'(ctr_strong_t));
        ghr_clear_i = 1'b1;
        settle();
        advance();
        set_lookup(32'h0000_2040, op_branch);
        settle();
        check_eq("pht_index_o after history clear", 32'(pht_index_o), 32'h10);
        advance();
    endtask

    task automatic test_tag_check();
        pending_t p;
        // same row as the trained branch, one row size further up
        set_lookup(32'h0000_2040 + 32'(btb_entries * 4), op_jal);
        settle();
        check_eq("pred_taken_o of aliasing PC", 32'(pred_taken_o), 32'd0);
        check_eq("pred_next_pc_o of aliasing PC", pred_next_pc_o, 32'h0000_20c4);
        capture(32'h0000_5000, 1'b1, p);
        // install a jump in the neighbouring row instead
        p.pc        = 32'h0000_2044;
        p.pred_next = 32'h0000_2048;
        advance();
        set_resolve(p);
        settle();
        advance();
        set_lookup(32'h0000_2040, op_jal);
        settle();
        check_eq("pred_taken_o of original PC", 32'(pred_taken_o), 32'd1);
        check_eq("pred_next_pc_o of original PC", pred_next_pc_o, 32'h0000_2100);
        advance();
    endtask

    task automatic test_correct_prediction();
        pending_t p;
        // the outcome follows the prediction, whatever the counter says
        set_lookup(32'h0000_2040, op_branch);
        settle();
        capture(32'h0000_2100, pred_taken_o, p);
        advance();
        set_resolve(p);
        settle();
        check_eq("mispredict_o of correct branch", 32'(mispredict_o), 32'd0);
        advance();
        // no redirect happened, but the counter has to move all the same
        check_eq("counter after correct taken",
                 32'(i_dut.i_gshare.pht_mem[p.index]), 32'(model_pht[p.index]));
        set_lookup(32'h0000_6000, op_branch);
        settle();
        capture(32'h0000_6100, 1'b0, p);
        advance();
        set_resolve(p);
        settle();
        check_eq("mispredict_o of correct not taken", 32'(mispredict_o), 32'd0);
        advance();
        check_eq("counter after correct not taken",
                 32'(i_dut.i_gshare.pht_mem[p.index]), 32'(model_pht[p.index]));
    endtask

    task automatic test_random(input int cycles);
        logic [31:0]     r;
        logic [xlen-1:0] pc;
        logic [6:0]      op;
        pending_t        p;
        for (int cyc = 0; cyc < cycles; cyc++) begin
            r = $random(seed);
            if (pending_q.size() > 0 && (r[0] || pending_q.size() > 3)) begin
                set_resolve(pending_q.pop_front());
            end
            ghr_clear_i = (r[5:1] == 5'd0);
            pc = 32'h0000_8000 + {24'h0, r[11:6], 2'b00} + (r[12] ? 32'h0001_0000 : 32'h0);
            case (r[14:13])
                2'd0:    op = op_branch;
                2'd1:    op = op_jal;
                2'd2:    op = op_jalr;
                default: op = op_addi;
            endcase
            set_lookup(pc, op);
            settle();
            if (op != op_addi) begin
                // branches lean taken so the counters actually move
                capture((op == op_jalr) ? 32'h0000_4000 + {22'h0, r[24:17], 2'b00}
                                        : pc + 32'h0000_0200,
                        (op != op_branch) || (r[16:15] != 2'b00), p);
                pending_q.push_back(p);
            end
            advance();
        end
    endtask

    initial begin
        seed        = 32'h45f4;
        checks_done = 0;
        drive_idle();
        reset_i = 1'b1;
        model_reset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        test_after_reset();
        test_jump_training();
        test_counter_history();
        test_tag_check();
        test_correct_prediction();
        test_random(400);
        if (checks_done > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("no checks were executed");
        end
    end

endmodule

// ==== tests/branch_predictor_properties.sv ====
module branch_predictor_properties (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    ex_valid_i,
    input logic                    mispredict_i,
    input logic                    pred_taken_i,
    input logic [bp_pkg::xlen-1:0] redirect_pc_i
);
    import bp_pkg::*;

    // a mispredict can only come from an instruction that is resolving this cycle
    property p_mispredict_needs_valid;
        @(posedge clk) disable iff (reset_i)
            !ex_valid_i |-> !mispredict_i;
    endproperty

    // every redirect goes to an instruction boundary
    property p_redirect_aligned;
        @(posedge clk) disable iff (reset_i)
            mispredict_i |-> (redirect_pc_i[1:0] == 2'b00);
    endproperty

    // the BTB is empty right after reset so nothing can be predicted taken
    property p_no_taken_after_reset;
        @(posedge clk)
            $fell(reset_i) |-> !pred_taken_i;
    endproperty

    a_mispredict_needs_valid: assert property (p_mispredict_needs_valid)
        else $error("mispredict_o is high while ex_valid_i is low");

    a_redirect_aligned: assert property (p_redirect_aligned)
        else $error("redirect_pc_o is not word aligned during a mispredict");

    a_no_taken_after_reset: assert property (p_no_taken_after_reset)
        else $error("pred_taken_o is high in the cycle after reset");

endmodule

// ==== source/branch_predictor.sv ====
module branch_predictor #(
    parameter int num_btb_entries = bp_pkg::default_btb_entries,
    parameter int num_ghr_bits    = bp_pkg::default_ghr_bits
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    ghr_clear_i,
    // fetch side lookup
    input  logic [bp_pkg::xlen-1:0] pc_i,
    input  logic [6:0]              op_i,
    output logic [bp_pkg::xlen-1:0] pred_next_pc_o,
    output logic                    pred_taken_o,
    output logic [num_ghr_bits-1:0] pht_index_o,
    // execute side resolve
    input  logic                    ex_valid_i,
    input  logic [6:0]              ex_op_i,
    input  logic [bp_pkg::xlen-1:0] ex_pc_i,
    input  logic [bp_pkg::xlen-1:0] ex_target_i,
    input  logic                    ex_taken_i,
    input  logic                    ex_pred_taken_i,
    input  logic [bp_pkg::xlen-1:0] ex_pred_next_pc_i,
    input  logic [num_ghr_bits-1:0] ex_pht_index_i,
    output logic                    mispredict_o,
    output logic [bp_pkg::xlen-1:0] redirect_pc_o
);
    import bp_pkg::*;

    logic            btb_hit;
    logic [xlen-1:0] btb_target;
    logic            pht_taken;
    logic            is_branch;
    logic            is_jump;

    // one training write per cycle from the resolver into both tables
    bp_update_if #(.num_ghr_bits(num_ghr_bits)) upd ();

    btb #(
        .num_btb_entries(num_btb_entries)
    ) i_btb (
        .clk      (clk),
        .reset_i  (reset_i),
        .pc_i     (pc_i),
        .hit_o    (btb_hit),
        .target_o (btb_target),
        .upd      (upd.btb_side)
    );

    gshare #(
        .num_ghr_bits(num_ghr_bits)
    ) i_gshare (
        .clk          (clk),
        .reset_i      (reset_i),
        .ghr_clear_i  (ghr_clear_i),
        .pc_i         (pc_i),
        .index_o      (pht_index_o),
        .pred_taken_o (pht_taken),
        .upd          (upd.pht_side)
    );

    branch_resolver #(
        .num_ghr_bits(num_ghr_bits)
    ) i_resolver (
        .ex_valid_i        (ex_valid_i),
        .ex_op_i           (ex_op_i),
        .ex_pc_i           (ex_pc_i),
        .ex_target_i       (ex_target_i),
        .ex_taken_i        (ex_taken_i),
        .ex_pred_taken_i   (ex_pred_taken_i),
        .ex_pred_next_pc_i (ex_pred_next_pc_i),
        .ex_pht_index_i    (ex_pht_index_i),
        .mispredict_o      (mispredict_o),
        .redirect_pc_o     (redirect_pc_o),
        .upd               (upd.resolver)
    );

    assign is_branch = (op_i == op_branch);
    assign is_jump   = (op_i == op_jal) || (op_i == op_jalr);

    // without a BTB hit there is no target to go to, so fall through
    // jumps are taken whenever the target is known, branches ask their counter
    assign pred_taken_o   = btb_hit && (is_jump || (is_branch && pht_taken));
    assign pred_next_pc_o = pred_taken_o ? btb_target : pc_i + 32'd4;

endmodule

// ==== source/branch_resolver.sv ====
module branch_resolver #(
    parameter int num_ghr_bits = bp_pkg::default_ghr_bits
) (
    input  logic                    ex_valid_i,
    input  logic [6:0]              ex_op_i,
    input  logic [bp_pkg::xlen-1:0] ex_pc_i,
    input  logic [bp_pkg::xlen-1:0] ex_target_i,
    input  logic                    ex_taken_i,
    input  logic                    ex_pred_taken_i,
    input  logic [bp_pkg::xlen-1:0] ex_pred_next_pc_i,
    input  logic [num_ghr_bits-1:0] ex_pht_index_i,
    output logic                    mispredict_o,
    output logic [bp_pkg::xlen-1:0] redirect_pc_o,
    bp_update_if.resolver           upd
);
    import bp_pkg::*;

    logic            is_branch;
    logic            is_jump;
    logic            is_ctrl;
    logic [xlen-1:0] fall_through;
    logic [xlen-1:0] actual_next;
    logic [xlen-1:0] pred_next;

    // only conditional branches train the direction predictor
    assign is_branch = (ex_op_i == op_branch);
    // jal and jalr are always taken, they only need a target
    assign is_jump   = (ex_op_i == op_jal) || (ex_op_i == op_jalr);
    assign is_ctrl   = is_branch || is_jump;

    assign fall_through = ex_pc_i + 32'd4;

    // where the instruction really went
    assign actual_next = ex_taken_i ? ex_target_i : fall_through;

    // a not taken guess always meant the sequential PC
    // a taken guess carries the BTB target that fetch used
    assign pred_next = ex_pred_taken_i ? ex_pred_next_pc_i : fall_through;

    // fetch went down the wrong path when the two next PCs disagree
    // non control instructions never leave the sequential path
    assign mispredict_o  = ex_valid_i && is_ctrl && (pred_next != actual_next);
    // the redirect is meaningful only together with mispredict_o
    assign redirect_pc_o = actual_next;

    // install every taken transfer so the next lookup finds its target
    assign upd.btb_we     = ex_valid_i && is_ctrl && ex_taken_i;
    // counters and history follow conditional branches only
    assign upd.pht_we     = ex_valid_i && is_branch;
    assign upd.upd_pc     = ex_pc_i;
    assign upd.upd_target = ex_target_i;
    assign upd.upd_taken  = ex_taken_i;
    assign upd.upd_index  = ex_pht_index_i;

endmodule

// ==== source/gshare.sv ====
module gshare #(
    parameter int num_ghr_bits = bp_pkg::default_ghr_bits
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    ghr_clear_i,
    input  logic [bp_pkg::xlen-1:0] pc_i,
    output logic [num_ghr_bits-1:0] index_o,
    output logic                    pred_taken_o,
    bp_update_if.pht_side           upd
);
    import bp_pkg::*;

    localparam int pht_entries = 2 ** num_ghr_bits;

    // global history, bit 0 holds the most recent branch outcome
    logic [num_ghr_bits-1:0] ghr_q;
    // one saturating counter per history and PC combination
    ctr_t                    pht_mem [pht_entries];

    // the counter that is about to be trained
    ctr_t upd_ctr;
    ctr_t upd_ctr_next;

    // the word address bits are hashed with the history to spread aliasing
    assign index_o = ghr_q ^ pc_i[num_ghr_bits+1:2];

    // the upper counter bit is the direction guess
    assign pred_taken_o = pht_mem[index_o][1];

    assign upd_ctr = pht_mem[upd.upd_index];

    // move one step toward the outcome and stick at either end
    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd.upd_taken) begin
            if (upd_ctr != ctr_strong_t) begin
                upd_ctr_next = upd_ctr + 2'd1;
            end
        end else begin
            if (upd_ctr != ctr_strong_nt) begin
                upd_ctr_next = upd_ctr - 2'd1;
            end
        end
    end

    // history register
    // a clear from outside wins over a shift in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (upd.pht_we) begin
            ghr_q <= {ghr_q[num_ghr_bits-2:0], upd.upd_taken};
        end
    end

    // pattern history table
    // reset puts every counter at weakly not taken so one taken outcome flips it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < pht_entries; i++) begin
                pht_mem[i] <= ctr_reset;
            end
        end else if (upd.pht_we) begin
            // the index comes from fetch, not from the current history
            pht_mem[upd.upd_index] <= upd_ctr_next;
        end
    end

endmodule

// ==== source/btb.sv ====
module btb #(
    parameter int num_btb_entries = bp_pkg::default_btb_entries
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [bp_pkg::xlen-1:0] pc_i,
    output logic                    hit_o,
    output logic [bp_pkg::xlen-1:0] target_o,
    bp_update_if.btb_side           upd
);
    import bp_pkg::*;

    // instructions are word aligned so the two low PC bits are skipped
    localparam int idx_bits = $clog2(num_btb_entries);
    // whatever is left above the row index becomes the tag
    localparam int tag_bits = xlen - idx_bits - 2;

    logic [xlen-1:0]     target_mem [num_btb_entries];
    logic [tag_bits-1:0] tag_mem    [num_btb_entries];
    logic [num_btb_entries-1:0] valid_q;

    logic [idx_bits-1:0] rd_idx;
    logic [tag_bits-1:0] rd_tag;
    logic [idx_bits-1:0] wr_idx;
    logic [tag_bits-1:0] wr_tag;

    // read and write split the PC the same way, so a written row is found again
    assign rd_idx = pc_i[idx_bits+1:2];
    assign rd_tag = pc_i[xlen-1:idx_bits+2];
    assign wr_idx = upd.upd_pc[idx_bits+1:2];
    assign wr_tag = upd.upd_pc[xlen-1:idx_bits+2];

    // lookup is purely combinational so fetch sees it in the same cycle
    // a row only counts when it was written since reset and the tag agrees
    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];

    // only the valid bits are control state, a stale row is simply ignored
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (upd.btb_we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // target and tag storage
    // a new taken transfer to the same row just overwrites the old one
    always_ff @(posedge clk) begin
        if (upd.btb_we) begin
            target_mem[wr_idx] <= upd.upd_target;
            tag_mem[wr_idx]    <= wr_tag;
        end
    end

endmodule

// ==== source/bp_update_if.sv ====
interface bp_update_if #(
    parameter int num_ghr_bits = bp_pkg::default_ghr_bits
);
    import bp_pkg::*;

    // strobes are single cycle, a strobe seen high at a rising edge commits there
    logic                    btb_we;
    logic                    pht_we;
    // the resolved instruction and what it actually did
    logic [xlen-1:0]         upd_pc;
    logic [xlen-1:0]         upd_target;
    logic                    upd_taken;
    // PHT index that fetch used for this instruction
    logic [num_ghr_bits-1:0] upd_index;

    // the resolver produces one training write per cycle
    modport resolver (
        output btb_we, pht_we, upd_pc, upd_target, upd_taken, upd_index
    );

    // the target table only needs the address and where it went
    modport btb_side (
        input btb_we, upd_pc, upd_target
    );

    // the direction predictor only needs the outcome and its counter index
    modport pht_side (
        input pht_we, upd_taken, upd_index
    );

endinterface

// ==== source/bp_pkg.sv ====
package bp_pkg;

    // width of a program counter or a target address
    localparam int xlen = 32;

    // default table sizes, the top level can override both
    localparam int default_btb_entries = 32;
    localparam int default_ghr_bits    = 5;

    // major opcodes of the control transfer instructions
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // a direction counter, bit 1 is the taken prediction
    typedef logic [1:0] ctr_t;

    // counter states from strongly not taken up to strongly taken
    localparam ctr_t ctr_strong_nt = 2'b00;
    localparam ctr_t ctr_weak_nt   = 2'b01;
    localparam ctr_t ctr_weak_t    = 2'b10;
    localparam ctr_t ctr_strong_t  = 2'b11;

    // every counter starts out weakly not taken
    localparam ctr_t ctr_reset = ctr_weak_nt;

endpackage
